// ==== mem_ctl_settings.svh ====
`ifndef MEM_CTL_SETTINGS_SVH
`define MEM_CTL_SETTINGS_SVH

// Top address byte of each serial memory region
`define MC_FLASH_REGION 8'h00
`define MC_PSRAM_REGION 8'h01

// Address bits 31..8 of the GPIO register page
`define MC_GPIO_PAGE 24'h020000
`define MC_GPIO_WIDTH 8

// SPI command bytes, same for flash and PSRAM
`define MC_SPI_READ_CMD 8'h03
`define MC_SPI_WRITE_CMD 8'h02

`endif

// ==== mem_ctl_pkg.sv ====
`include "mem_ctl_settings.svh"

package mem_ctl_pkg;

    // Address or data word as seen by the core
    typedef logic [31:0] word_t;

    // Byte offset inside one serial memory
    typedef logic [23:0] spi_addr_t;

    // Access size from funct3
    typedef logic [2:0] mem_flag_t;

    // Number of data bits in one SPI job (8, 16 or 32)
    typedef logic [5:0] bit_len_t;

    typedef logic [`MC_GPIO_WIDTH-1:0] gpio_t;

    typedef enum logic [1:0] {
        req_idle,
        req_spi_wait,
        req_respond
    } req_state_t;

    typedef enum logic [1:0] {
        spi_idle,
        spi_shift_out,
        spi_shift_in,
        spi_finish
    } spi_state_t;

endpackage

// ==== spi_cmd_if.sv ====
`timescale 1ns/1ns

// Job handoff from the request controller to the SPI master
interface spi_cmd_if;

    logic                   start;
    logic                   write;
    logic                   to_flash;
    mem_ctl_pkg::spi_addr_t addr;
    mem_ctl_pkg::bit_len_t  bit_len;
    mem_ctl_pkg::word_t     wdata;
    mem_ctl_pkg::word_t     rdata;
    logic                   done;

    modport ctl (
        output start, write, to_flash, addr, bit_len, wdata,
        input  rdata, done
    );

    modport master (
        input  start, write, to_flash, addr, bit_len, wdata,
        output rdata, done
    );

endinterface

// ==== mem_req_ctl.sv ====
`timescale 1ns/1ns
`include "mem_ctl_settings.svh"

module mem_req_ctl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_ctl_pkg::word_t     mem_addr,
    input  mem_ctl_pkg::word_t     mem_wdata,
    input  mem_ctl_pkg::mem_flag_t mem_flag,
    input  logic                   mem_we,
    input  logic                   mem_re,
    output mem_ctl_pkg::word_t     mem_rdata,
    output logic                   mem_ready,
    output mem_ctl_pkg::gpio_t     gpio_out,
    spi_cmd_if.ctl                 spi
);

    mem_ctl_pkg::req_state_t state;
    mem_ctl_pkg::bit_len_t   req_len;
    logic                    req;
    logic                    is_gpio;
    logic                    is_flash;
    logic                    is_psram;

    function automatic mem_ctl_pkg::bit_len_t flag_to_len(input mem_ctl_pkg::mem_flag_t flag);
        case (flag)
            3'b000, 3'b100: return 6'd8;
            3'b001, 3'b101: return 6'd16;
            default: return 6'd32;
        endcase
    endfunction

    function automatic mem_ctl_pkg::word_t byte_swap(input mem_ctl_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Serial data arrives lowest byte first and left aligned
    function automatic mem_ctl_pkg::word_t format_load(
        input mem_ctl_pkg::word_t    raw,
        input mem_ctl_pkg::bit_len_t len
    );
        mem_ctl_pkg::word_t swapped;
        swapped = byte_swap(raw);
        case (len)
            6'd8:    return {24'h0, swapped[7:0]};
            6'd16:   return {16'h0, swapped[15:0]};
            default: return swapped;
        endcase
    endfunction

    assign req      = mem_we | mem_re;
    assign req_len  = flag_to_len(mem_flag);
    assign is_gpio  = mem_addr[31:8] == `MC_GPIO_PAGE;
    assign is_flash = mem_addr[31:24] == `MC_FLASH_REGION;
    assign is_psram = mem_addr[31:24] == `MC_PSRAM_REGION;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mem_ctl_pkg::req_idle;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            gpio_out  <= '0;
            spi.start <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            spi.start <= 1'b0;
            case (state)
                mem_ctl_pkg::req_idle: begin
                    if (req) begin
                        if (is_gpio) begin
                            if (mem_we) begin
                                gpio_out <= mem_wdata[`MC_GPIO_WIDTH-1:0];
                            end else begin
                                mem_rdata <= {{(32 - `MC_GPIO_WIDTH){1'b0}}, gpio_out};
                            end
                            mem_ready <= 1'b1;
                            state     <= mem_ctl_pkg::req_respond;
                        end else if (is_flash || is_psram) begin
                            spi.start <= 1'b1;
                            state     <= mem_ctl_pkg::req_spi_wait;
                        end else begin
                            // Nothing mapped here, finish with zero
                            mem_rdata <= '0;
                            mem_ready <= 1'b1;
                            state     <= mem_ctl_pkg::req_respond;
                        end
                    end
                end
                mem_ctl_pkg::req_spi_wait: begin
                    if (spi.done) begin
                        if (!spi.write) begin
                            mem_rdata <= format_load(spi.rdata, req_len);
                        end
                        mem_ready <= 1'b1;
                        state     <= mem_ctl_pkg::req_respond;
                    end
                end
                mem_ctl_pkg::req_respond: begin
                    state <= mem_ctl_pkg::req_idle;
                end
                default: state <= mem_ctl_pkg::req_idle;
            endcase
        end
    end

    // Job fields, held until the master reports done
    always_ff @(posedge clk) begin
        if (state == mem_ctl_pkg::req_idle && req) begin
            spi.write    <= mem_we;
            spi.to_flash <= is_flash;
            spi.addr     <= mem_addr[23:0];
            spi.bit_len  <= req_len;
            // Lowest byte goes out first, the master sends from the top
            spi.wdata    <= byte_swap(mem_wdata);
        end
    end

    a_req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> state == mem_ctl_pkg::req_idle)
        else $error("core request while a previous request is still open");

    a_we_re_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_we && mem_re))
        else $error("mem_we and mem_re high together");

    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        spi.done |-> state == mem_ctl_pkg::req_spi_wait)
        else $error("SPI done while no SPI job is open");

endmodule

// ==== spi_master.sv ====
`timescale 1ns/1ns
`include "mem_ctl_settings.svh"

module spi_master (
    input  logic      clk,
    input  logic      rst_n,
    spi_cmd_if.master spi,
    output logic      flash_cs_n,
    output logic      ram_cs_n,
    output logic      sclk,
    output logic      mosi,
    input  logic      miso
);

    mem_ctl_pkg::spi_state_t state;
    mem_ctl_pkg::word_t      rx_q;
    logic [6:0]              bits_left;
    logic [63:0]             tx_q;
    logic [7:0]              cmd;
    logic [5:0]              align;

    assign cmd       = spi.write ? `MC_SPI_WRITE_CMD : `MC_SPI_READ_CMD;
    assign align     = 6'd32 - spi.bit_len;
    assign mosi      = tx_q[63];
    assign spi.rdata = rx_q;

    // SCLK toggles every clk while shifting, so one bit takes two cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= mem_ctl_pkg::spi_idle;
            bits_left  <= '0;
            sclk       <= 1'b0;
            flash_cs_n <= 1'b1;
            ram_cs_n   <= 1'b1;
            spi.done   <= 1'b0;
        end else begin
            spi.done <= 1'b0;
            case (state)
                mem_ctl_pkg::spi_idle: begin
                    if (spi.start) begin
                        flash_cs_n <= !spi.to_flash;
                        ram_cs_n   <= spi.to_flash;
                        // Command and address, plus store data for a write
                        bits_left  <= 7'd32 + (spi.write ? {1'b0, spi.bit_len} : 7'd0);
                        state      <= mem_ctl_pkg::spi_shift_out;
                    end
                end
                mem_ctl_pkg::spi_shift_out: begin
                    sclk <= !sclk;
                    if (sclk) begin
                        if (bits_left == 7'd1) begin
                            if (spi.write) begin
                                flash_cs_n <= 1'b1;
                                ram_cs_n   <= 1'b1;
                                state      <= mem_ctl_pkg::spi_finish;
                            end else begin
                                bits_left <= {1'b0, spi.bit_len};
                                state     <= mem_ctl_pkg::spi_shift_in;
                            end
                        end else begin
                            bits_left <= bits_left - 7'd1;
                        end
                    end
                end
                mem_ctl_pkg::spi_shift_in: begin
                    sclk <= !sclk;
                    if (!sclk) begin
                        bits_left <= bits_left - 7'd1;
                    end else if (bits_left == 7'd0) begin
                        flash_cs_n <= 1'b1;
                        ram_cs_n   <= 1'b1;
                        state      <= mem_ctl_pkg::spi_finish;
                    end
                end
                mem_ctl_pkg::spi_finish: begin
                    spi.done <= 1'b1;
                    state    <= mem_ctl_pkg::spi_idle;
                end
                default: state <= mem_ctl_pkg::spi_idle;
            endcase
        end
    end

    // Shift registers, MSB first in both directions
    always_ff @(posedge clk) begin
        case (state)
            mem_ctl_pkg::spi_idle: begin
                if (spi.start) begin
                    tx_q <= {cmd, spi.addr, spi.wdata};
                    rx_q <= '0;
                end
            end
            mem_ctl_pkg::spi_shift_out: begin
                // Next bit appears on the falling edge
                if (sclk) begin
                    tx_q <= {tx_q[62:0], 1'b0};
                end
            end
            mem_ctl_pkg::spi_shift_in: begin
                // Sample together with the rising edge
                if (!sclk) begin
                    rx_q <= {rx_q[30:0], miso};
                end
            end
            mem_ctl_pkg::spi_finish: begin
                // First received bit ends up at bit 31
                rx_q <= rx_q << align;
            end
            default: ;
        endcase
    end

    // Only the chip named by the held job may be selected, never both
    a_one_cs: assert property (@(posedge clk) disable iff (!rst_n)
        (flash_cs_n || spi.to_flash) && (ram_cs_n || !spi.to_flash))
        else $error("chip select low for a memory the job does not address");

    a_start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        spi.start |-> state == mem_ctl_pkg::spi_idle)
        else $error("SPI job started while a transfer is running");

endmodule

// ==== mem_ctl_top.sv ====
`timescale 1ns/1ns

module mem_ctl_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // Core data port
    input  mem_ctl_pkg::word_t     mem_addr,
    input  mem_ctl_pkg::word_t     mem_wdata,
    input  mem_ctl_pkg::mem_flag_t mem_flag,
    input  logic                   mem_we,
    input  logic                   mem_re,
    output mem_ctl_pkg::word_t     mem_rdata,
    output logic                   mem_ready,

    output mem_ctl_pkg::gpio_t     gpio_out,

    // Shared single-lane SPI bus
    output logic                   flash_cs_n,
    output logic                   ram_cs_n,
    output logic                   spi_sclk,
    output logic                   spi_mosi,
    input  logic                   spi_miso
);

    spi_cmd_if spi_bus ();

    mem_req_ctl i_mem_req_ctl (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_flag  (mem_flag),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .gpio_out  (gpio_out),
        .spi       (spi_bus.ctl)
    );

    spi_master i_spi_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .spi        (spi_bus.master),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .sclk       (spi_sclk),
        .mosi       (spi_mosi),
        .miso       (spi_miso)
    );

endmodule

// ==== spi_mem_model.sv ====
`timescale 1ns/1ns
`include "mem_ctl_settings.svh"

// Single-lane SPI flash and PSRAM in mode 0, sharing SCLK, MOSI and MISO
module spi_mem_model (
    input  logic flash_cs_n,
    input  logic ram_cs_n,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    // Only the low 12 address bits are decoded
    logic [7:0]  flash_mem [0:4095] = '{default: 8'h00};
    logic [7:0]  ram_mem [0:4095] = '{default: 8'h00};
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [7:0]  shreg;
    logic        sel_flash;
    logic        idle;
    int          bit_cnt = 0;

    assign idle = flash_cs_n & ram_cs_n;

    initial miso = 1'b0;

    // Command, address and store data are taken on the rising edge
    always @(posedge sclk or posedge idle) begin
        int          d;
        logic [23:0] a;
        if (idle) begin
            bit_cnt = 0;
        end else begin
            if (bit_cnt == 0) begin
                sel_flash = !flash_cs_n;
            end
            if (bit_cnt < 8) begin
                cmd = {cmd[6:0], mosi};
            end else if (bit_cnt < 32) begin
                addr = {addr[22:0], mosi};
            end else if (cmd == `MC_SPI_WRITE_CMD) begin
                d     = bit_cnt - 32;
                shreg = {shreg[6:0], mosi};
                // Byte complete, store it and move to the next address
                if (d % 8 == 7) begin
                    a = addr + 24'(d / 8);
                    if (sel_flash) begin
                        flash_mem[a[11:0]] = shreg;
                    end else begin
                        ram_mem[a[11:0]] = shreg;
                    end
                end
            end
            bit_cnt++;
        end
    end

    // Load data goes out on the falling edge, MSB of each byte first
    always @(negedge sclk) begin
        int          d;
        logic [23:0] a;
        logic [7:0]  rd_byte;
        if (!idle && bit_cnt >= 32 && cmd == `MC_SPI_READ_CMD) begin
            d       = bit_cnt - 32;
            a       = addr + 24'(d / 8);
            rd_byte = sel_flash ? flash_mem[a[11:0]] : ram_mem[a[11:0]];
            miso    = rd_byte[3'(7 - d % 8)];
        end
    end

endmodule

// ==== mem_ctl_checker.sv ====
`timescale 1ns/1ns
`include "mem_ctl_settings.svh"

module mem_ctl_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_ctl_pkg::word_t mem_addr,
    input  mem_ctl_pkg::word_t mem_wdata,
    input  logic               mem_we,
    input  logic               mem_re,
    input  mem_ctl_pkg::word_t mem_rdata,
    input  logic               mem_ready,
    input  mem_ctl_pkg::gpio_t gpio_out,
    input  logic               flash_cs_n,
    input  logic               ram_cs_n,
    input  mem_ctl_pkg::word_t exp_rdata,
    output int                 tests_done,
    output int                 checks_failed
);

    mem_ctl_pkg::word_t req_addr;
    mem_ctl_pkg::word_t req_wdata;
    mem_ctl_pkg::word_t exp_word;
    mem_ctl_pkg::gpio_t gpio_model;
    logic               busy;
    logic               is_load;
    logic               flash_low;
    logic               ram_low;
    logic               test_ok;
    int                 lat;

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        checks_failed++;
        test_ok = 1'b0;
    endtask

    task automatic close_test();
        logic gpio_hit;
        logic flash_hit;
        logic ram_hit;
        gpio_hit  = req_addr[31:8] == `MC_GPIO_PAGE;
        flash_hit = req_addr[31:24] == `MC_FLASH_REGION;
        ram_hit   = req_addr[31:24] == `MC_PSRAM_REGION;
        test_ok   = 1'b1;
        if (gpio_hit && !is_load) begin
            gpio_model = req_wdata[`MC_GPIO_WIDTH-1:0];
        end
        if (is_load && mem_rdata !== exp_word) begin
            flag_error($sformatf("load from %h returned %h, expected %h",
                req_addr, mem_rdata, exp_word));
        end
        if (gpio_out !== gpio_model) begin
            flag_error($sformatf("gpio_out is %h, expected %h", gpio_out, gpio_model));
        end
        if (flash_hit) begin
            if (ram_low) begin
                flag_error("ram_cs_n went low during a flash access");
            end
            if (!flash_low) begin
                flag_error("flash_cs_n never went low during a flash access");
            end
        end else if (ram_hit) begin
            if (flash_low) begin
                flag_error("flash_cs_n went low during a PSRAM access");
            end
            if (!ram_low) begin
                flag_error("ram_cs_n never went low during a PSRAM access");
            end
        end else begin
            // GPIO and unmapped requests finish in one cycle
            if (lat != 1) begin
                flag_error($sformatf("mem_ready came %0d cycles after the request, expected 1",
                    lat));
            end
            if (flash_low || ram_low) begin
                flag_error("a chip select went low for an address outside flash and PSRAM");
            end
        end
        tests_done++;
        $display("Test %0d: %s %h %s", tests_done, is_load ? "load " : "store", req_addr,
            test_ok ? "ok" : "failed");
    endtask

    // DUT outputs are sampled at the rising edge, before they update
    always @(posedge clk) begin
        if (!rst_n) begin
            busy          = 1'b0;
            lat           = 0;
            flash_low     = 1'b0;
            ram_low       = 1'b0;
            gpio_model    = '0;
            tests_done    = 0;
            checks_failed = 0;
        end else begin
            if (busy) begin
                lat++;
                if (!flash_cs_n) begin
                    flash_low = 1'b1;
                end
                if (!ram_cs_n) begin
                    ram_low = 1'b1;
                end
            end
            if (mem_ready) begin
                if (busy) begin
                    close_test();
                    busy = 1'b0;
                end else begin
                    $display("Error at %0t ns: mem_ready pulsed with no request open", $time);
                    checks_failed++;
                end
            end
            if (mem_we || mem_re) begin
                busy      = 1'b1;
                lat       = 0;
                flash_low = 1'b0;
                ram_low   = 1'b0;
                is_load   = mem_re;
                req_addr  = mem_addr;
                req_wdata = mem_wdata;
                exp_word  = exp_rdata;
            end
        end
    end

endmodule

// ==== tb_mem_ctl.sv ====
`timescale 1ns/1ns

module tb_mem_ctl;

    localparam int MAX_WAIT = 400;

    logic                   clk;
    logic                   rst_n;
    mem_ctl_pkg::word_t     mem_addr;
    mem_ctl_pkg::word_t     mem_wdata;
    mem_ctl_pkg::mem_flag_t mem_flag;
    logic                   mem_we;
    logic                   mem_re;
    mem_ctl_pkg::word_t     mem_rdata;
    logic                   mem_ready;
    mem_ctl_pkg::gpio_t     gpio_out;
    logic                   flash_cs_n;
    logic                   ram_cs_n;
    logic                   spi_sclk;
    logic                   spi_mosi;
    logic                   spi_miso;
    mem_ctl_pkg::word_t     exp_rdata;
    int                     tests_done;
    int                     checks_failed;
    int                     requests;
    int                     timeouts;

    mem_ctl_top i_mem_ctl_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_flag   (mem_flag),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .gpio_out   (gpio_out),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    spi_mem_model i_spi_mem_model (
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .sclk       (spi_sclk),
        .mosi       (spi_mosi),
        .miso       (spi_miso)
    );

    mem_ctl_checker i_mem_ctl_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_we        (mem_we),
        .mem_re        (mem_re),
        .mem_rdata     (mem_rdata),
        .mem_ready     (mem_ready),
        .gpio_out      (gpio_out),
        .flash_cs_n    (flash_cs_n),
        .ram_cs_n      (ram_cs_n),
        .exp_rdata     (exp_rdata),
        .tests_done    (tests_done),
        .checks_failed (checks_failed)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // One-cycle request pulse, then poll mem_ready mid-cycle
    task automatic issue_request(
        input  int                     op,
        input  mem_ctl_pkg::mem_flag_t flag,
        input  mem_ctl_pkg::word_t     addr,
        input  mem_ctl_pkg::word_t     wdata,
        input  mem_ctl_pkg::word_t     expw,
        output logic                   timed_out
    );
        int wait_cycles;
        @(posedge clk);
        #1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_flag  = flag;
        exp_rdata = expw;
        mem_we    = (op == 0);
        mem_re    = (op != 0);
        @(posedge clk);
        #1;
        mem_we      = 1'b0;
        mem_re      = 1'b0;
        wait_cycles = 0;
        while (!mem_ready && wait_cycles < MAX_WAIT) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        timed_out = !mem_ready;
        requests++;
    endtask

    initial begin
        int                 fd;
        int                 n;
        int                 op;
        string              line;
        mem_ctl_pkg::word_t flag_w;
        mem_ctl_pkg::word_t addr_w;
        mem_ctl_pkg::word_t wdata_w;
        mem_ctl_pkg::word_t exp_w;
        logic               timed_out;
        logic               file_ok;
        rst_n     = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_flag  = '0;
        mem_we    = 1'b0;
        mem_re    = 1'b0;
        exp_rdata = '0;
        requests  = 0;
        timeouts  = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd      = $fopen("mem_ctl_stim.txt", "r");
        file_ok = fd != 0;
        if (!file_ok) begin
            $display("Error: cannot open the stimulus file mem_ctl_stim.txt");
        end else begin
            // Lines that do not hold five fields are comments
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %h %h %h %h", op, flag_w, addr_w, wdata_w, exp_w);
                if (n == 5) begin
                    issue_request(op, flag_w[2:0], addr_w, wdata_w, exp_w, timed_out);
                    if (timed_out) begin
                        $display("Timeout: no mem_ready within %0d cycles for the request to %h",
                            MAX_WAIT, addr_w);
                        timeouts++;
                    end
                end
            end
            $fclose(fd);
        end
        // Let the checker close the last request
        repeat (2) @(posedge clk);
        #1;
        if (tests_done != requests) begin
            $display("Error: %0d requests were issued but %0d of them completed",
                requests, tests_done);
        end
        $display("Tests: %0d, checks failed: %0d, timeouts: %0d",
            tests_done, checks_failed, timeouts);
        if (file_ok && requests > 0 && tests_done == requests && timeouts == 0 &&
                checks_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== mem_ctl_stim.txt ====
# op (0 store, 1 load), flag (funct3 size code), address, write data, expected load data
# all fields after op are hex
0 2 01000010 a1b2c3d4 00000000
1 2 01000010 00000000 a1b2c3d4
1 2 00000010 00000000 00000000
0 0 01000020 deadbe11 00000000
0 4 01000021 00000022 00000000
0 1 01000022 99884433 00000000
1 2 01000020 00000000 44332211
1 0 01000023 00000000 00000044
1 4 01000022 00000000 00000033
1 5 01000021 00000000 00003322
1 0 01000012 00000000 000000b2
1 1 01000010 00000000 0000c3d4
0 2 00000100 cafef00d 00000000
1 2 00000100 00000000 cafef00d
1 2 01000100 00000000 00000000
0 2 02000004 123456a5 00000000
1 2 02000000 00000000 000000a5
1 2 05000040 00000000 00000000
0 2 7f000000 ffffffff 00000000
1 6 01000010 00000000 a1b2c3d4

// ==== list.f ====
+incdir+.
mem_ctl_pkg.sv
spi_cmd_if.sv
mem_req_ctl.sv
spi_master.sv
mem_ctl_top.sv
spi_mem_model.sv
mem_ctl_checker.sv
tb_mem_ctl.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_mem_ctl -f list.f -o tb_mem_ctl
	@out="$$(./obj_dir/tb_mem_ctl)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
